// File: Makefile
VERILATOR ?= verilator
TOP       ?= mips_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
PASS_MSG  ?= Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: hdl/mips_control.sv
`timescale 1ns/1ns
`default_nettype none

module mips_control (
    input  logic               clk,
    input  logic               rst,
    input  logic               run,
    input  mips_pkg::decoded_t dec,
    input  logic               zero,
    output mips_pkg::state_e   state,
    output mips_pkg::ctrl_t    ctrl
);
    import mips_pkg::*;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_fetch;
        end else begin
            case (state)
                st_fetch: begin
                    // hold here while stopped
                    if (run) begin
                        state <= st_decode;
                    end
                end
                st_decode: begin
                    case (dec.op)
                        alu_reg, alu_imm:  state <= st_alu_exe;
                        lui_op:            state <= st_lui_wb;
                        load_op, store_op: state <= st_mem_addr;
                        beq_op:            state <= st_beq_exe;
                        jal_op:            state <= st_jal_exe;
                        shift_op:          state <= st_shift_exe;
                        default:           state <= st_fetch;
                    endcase
                end
                st_alu_exe:   state <= st_alu_wb;
                st_shift_exe: state <= st_shift_wb;
                st_mem_addr:  state <= (dec.op == store_op) ? st_mem_store : st_mem_load;
                st_mem_load:  state <= st_mem_wb;
                default:      state <= st_fetch;
            endcase
        end
    end

    always_comb begin
        ctrl = '0;
        ctrl.wb_src = wb_alu;
        ctrl.npc = npc_seq;
        case (state)
            st_fetch: begin
                ctrl.pc_we = run;
                ctrl.ir_we = run;
            end
            st_alu_exe: ctrl.op2_imm = (dec.op == alu_imm);
            st_alu_wb:  ctrl.rf_we = 1'b1;
            st_mem_addr, st_mem_load: ctrl.op2_imm = 1'b1;
            st_mem_store: begin
                ctrl.op2_imm = 1'b1;
                ctrl.dm_we = 1'b1;
            end
            st_mem_wb: begin
                ctrl.rf_we = 1'b1;
                ctrl.wb_src = wb_mem;
            end
            st_beq_exe: begin
                // taken only when operands match
                ctrl.pc_we = zero;
                ctrl.npc = npc_branch;
            end
            st_jal_exe: begin
                ctrl.pc_we = 1'b1;
                ctrl.rf_we = 1'b1;
                ctrl.npc = npc_jump;
                ctrl.wb_src = wb_link;
            end
            st_lui_wb: begin
                ctrl.rf_we = 1'b1;
                ctrl.wb_src = wb_imm;
            end
            st_shift_wb: begin
                ctrl.rf_we = 1'b1;
                ctrl.wb_src = wb_shift;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/mips_core.sv
`timescale 1ns/1ns
`default_nettype none

module mips_core (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            run,
    input  logic                            prog_we,
    input  logic [mips_pkg::mem_addr_w-1:0] prog_addr,
    input  mips_pkg::word_t                 prog_data,
    output mips_pkg::rf_write_t             rf_trace,
    output logic                            integer_overflow
);
    import mips_pkg::*;

    word_t     pc;
    word_t     npc;
    word_t     ir;
    word_t     imem_rdata;
    word_t     dmem_rdata;
    decoded_t  dec;
    state_e    state;
    ctrl_t     ctrl;
    word_t     rs_data;
    word_t     rt_data;
    word_t     rs_q;
    word_t     rt_q;
    word_t     alu_result;
    word_t     shift_result;
    word_t     imm_ext;
    word_t     alu_q;
    word_t     shift_q;
    word_t     mem_q;
    logic      zero;
    logic      overflow;
    logic      ovf_q;
    word_t     wb_data;
    rf_write_t rf_wr;

    word_ram #(.depth(imem_words)) imem (
        .clk(clk), .we(prog_we), .waddr(prog_addr), .wdata(prog_data),
        .raddr(pc[mem_addr_w+1:2]), .rdata(imem_rdata)
    );

    word_ram #(.depth(dmem_words)) dmem (
        .clk(clk), .we(ctrl.dm_we), .waddr(alu_q[mem_addr_w+1:2]), .wdata(rt_q),
        .raddr(alu_q[mem_addr_w+1:2]), .rdata(dmem_rdata)
    );

    mips_decoder decoder_i (.instr(ir), .dec(dec));

    mips_control control_i (
        .clk(clk), .rst(rst), .run(run), .dec(dec), .zero(zero), .state(state), .ctrl(ctrl)
    );

    mips_regfile regfile_i (
        .clk(clk), .rst(rst), .rs_addr(dec.rs), .rt_addr(dec.rt),
        .rs_data(rs_data), .rt_data(rt_data), .wr(rf_wr)
    );

    mips_execute execute_i (
        .dec(dec), .op1(rs_q), .op2_reg(rt_q), .op2_is_imm(ctrl.op2_imm),
        .result(alu_result), .shift_result(shift_result), .imm_ext(imm_ext),
        .zero(zero), .overflow(overflow)
    );

    always_comb begin
        case (ctrl.npc)
            npc_branch: npc = pc + {imm_ext[xlen-3:0], 2'b00};
            npc_jump:   npc = {pc[31:28], dec.jidx, 2'b00};
            default:    npc = pc + 32'd4;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= '0;
            ir <= '0;
            ovf_q <= 1'b0;
        end else begin
            if (ctrl.pc_we) begin
                pc <= npc;
            end
            if (ctrl.ir_we) begin
                ir <= imem_rdata;
            end
            ovf_q <= overflow;
        end
    end

    // operand and result registers refresh every cycle
    always_ff @(posedge clk) begin
        rs_q <= rs_data;
        rt_q <= rt_data;
        alu_q <= alu_result;
        shift_q <= shift_result;
        mem_q <= dmem_rdata;
    end

    assign integer_overflow = (state == st_alu_wb) && ovf_q;

    always_comb begin
        case (ctrl.wb_src)
            wb_mem:   wb_data = mem_q;
            wb_link:  wb_data = pc;
            wb_imm:   wb_data = imm_ext;
            wb_shift: wb_data = shift_q;
            default:  wb_data = alu_q;
        endcase
    end

    // an overflowing write is dropped
    assign rf_wr.valid = ctrl.rf_we && !integer_overflow && (dec.dst != '0);
    assign rf_wr.addr = dec.dst;
    assign rf_wr.data = wb_data;
    assign rf_trace = rf_wr;

endmodule

`default_nettype wire

// File: hdl/mips_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module mips_decoder (
    input  mips_pkg::word_t    instr,
    output mips_pkg::decoded_t dec
);
    import mips_pkg::*;

    opcode_e opcode;
    funct_e  funct;
    logic    r_alu;

    assign opcode = opcode_e'(instr[31:26]);
    assign funct = funct_e'(instr[5:0]);
    assign r_alu = funct inside {f_add, f_addu, f_sub, f_subu, f_and, f_or, f_xor, f_nor,
                                 f_slt, f_sltu};

    always_comb begin
        dec = '0;
        dec.op = illegal_op;
        dec.alu_op = alu_add;
        dec.ext = ext_sign;
        dec.rs = instr[25:21];
        dec.rt = instr[20:16];
        dec.dst = instr[20:16];
        dec.shamt = instr[10:6];
        dec.imm = instr[15:0];
        dec.jidx = instr[25:0];
        case (opcode)
            op_special: begin
                dec.dst = instr[15:11];
                case (funct)
                    f_sub, f_subu: dec.alu_op = alu_sub;
                    f_and:  dec.alu_op = alu_and;
                    f_or:   dec.alu_op = alu_or;
                    f_xor:  dec.alu_op = alu_xor;
                    f_nor:  dec.alu_op = alu_nor;
                    f_slt:  dec.alu_op = alu_slt;
                    f_sltu: dec.alu_op = alu_sltu;
                    default: dec.alu_op = alu_add;
                endcase
                // required-zero fields per form
                if (r_alu && instr[10:6] == 5'd0) begin
                    dec.op = alu_reg;
                    dec.check_ovf = (funct == f_add) || (funct == f_sub);
                end else if (funct == f_sll && instr[25:21] == 5'd0) begin
                    dec.op = shift_op;
                end else if (funct == f_sllv && instr[10:6] == 5'd0) begin
                    dec.op = shift_op;
                    dec.shift_var = 1'b1;
                end
            end
            op_addi, op_addiu, op_slti, op_sltiu, op_andi, op_ori, op_xori: begin
                dec.op = alu_imm;
                case (opcode)
                    op_slti:  dec.alu_op = alu_slt;
                    op_sltiu: dec.alu_op = alu_sltu;
                    op_andi:  dec.alu_op = alu_and;
                    op_ori:   dec.alu_op = alu_or;
                    op_xori:  dec.alu_op = alu_xor;
                    default:  dec.alu_op = alu_add;
                endcase
                // logical immediates are zero-extended
                if (opcode inside {op_andi, op_ori, op_xori}) begin
                    dec.ext = ext_zero;
                end
                dec.check_ovf = (opcode == op_addi);
            end
            op_lui: begin
                if (instr[25:21] == 5'd0) begin
                    dec.op = lui_op;
                end
                dec.ext = ext_upper;
            end
            op_lw: dec.op = load_op;
            op_sw: dec.op = store_op;
            op_beq: begin
                dec.op = beq_op;
                dec.alu_op = alu_sub;
            end
            op_jal: begin
                dec.op = jal_op;
                dec.dst = reg_addr_t'(ra_reg);
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/mips_execute.sv
`timescale 1ns/1ns
`default_nettype none

module mips_execute (
    input  mips_pkg::decoded_t dec,
    input  mips_pkg::word_t    op1,
    input  mips_pkg::word_t    op2_reg,
    input  logic               op2_is_imm,
    output mips_pkg::word_t    result,
    output mips_pkg::word_t    shift_result,
    output mips_pkg::word_t    imm_ext,
    output logic               zero,
    output logic               overflow
);
    import mips_pkg::*;

    word_t      op2;
    word_t      sum;
    word_t      diff;
    logic [4:0] shift_amt;
    logic       ovf_add;
    logic       ovf_sub;

    always_comb begin
        case (dec.ext)
            ext_zero:  imm_ext = {16'h0000, dec.imm};
            ext_upper: imm_ext = {dec.imm, 16'h0000};
            default:   imm_ext = {{16{dec.imm[15]}}, dec.imm};
        endcase
    end

    assign op2 = op2_is_imm ? imm_ext : op2_reg;
    assign sum = op1 + op2;
    assign diff = op1 - op2;

    always_comb begin
        case (dec.alu_op)
            alu_sub:  result = diff;
            alu_or:   result = op1 | op2;
            alu_slt:  result = {{(xlen-1){1'b0}}, $signed(op1) < $signed(op2)};
            alu_sltu: result = {{(xlen-1){1'b0}}, op1 < op2};
            alu_and:  result = op1 & op2;
            alu_nor:  result = ~(op1 | op2);
            alu_xor:  result = op1 ^ op2;
            default:  result = sum;
        endcase
    end

    // sllv takes the amount from rs
    assign shift_amt = dec.shift_var ? op1[4:0] : dec.shamt;
    assign shift_result = op2_reg << shift_amt;

    // signed overflow from the operand and result signs
    assign ovf_add = (op1[xlen-1] == op2[xlen-1]) && (sum[xlen-1] != op1[xlen-1]);
    assign ovf_sub = (op1[xlen-1] != op2[xlen-1]) && (diff[xlen-1] != op1[xlen-1]);
    assign overflow = dec.check_ovf && ((dec.alu_op == alu_sub) ? ovf_sub : ovf_add);

    assign zero = (op1 == op2_reg);

endmodule

`default_nettype wire

// File: hdl/mips_pkg.sv
`default_nettype none

package mips_pkg;

    localparam int xlen = 32;
    localparam int imem_words = 256;
    localparam int dmem_words = 256;
    localparam int mem_addr_w = 8;
    localparam int ra_reg = 31;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0] reg_addr_t;

    // primary opcodes in scope
    typedef enum logic [5:0] {
        op_special = 6'b00_0000,
        op_jal     = 6'b00_0011,
        op_beq     = 6'b00_0100,
        op_addi    = 6'b00_1000,
        op_addiu   = 6'b00_1001,
        op_slti    = 6'b00_1010,
        op_sltiu   = 6'b00_1011,
        op_andi    = 6'b00_1100,
        op_ori     = 6'b00_1101,
        op_xori    = 6'b00_1110,
        op_lui     = 6'b00_1111,
        op_lw      = 6'b10_0011,
        op_sw      = 6'b10_1011
    } opcode_e;

    // function codes under op_special
    typedef enum logic [5:0] {
        f_sll  = 6'b000_000,
        f_sllv = 6'b000_100,
        f_add  = 6'b100_000,
        f_addu = 6'b100_001,
        f_sub  = 6'b100_010,
        f_subu = 6'b100_011,
        f_and  = 6'b100_100,
        f_or   = 6'b100_101,
        f_xor  = 6'b100_110,
        f_nor  = 6'b100_111,
        f_slt  = 6'b101_010,
        f_sltu = 6'b101_011
    } funct_e;

    typedef enum logic [3:0] {
        alu_reg, alu_imm, lui_op, shift_op, load_op, store_op, beq_op, jal_op, illegal_op
    } instr_op_e;

    typedef enum logic [2:0] {
        alu_add, alu_sub, alu_or, alu_slt, alu_sltu, alu_and, alu_nor, alu_xor
    } alu_op_e;

    typedef enum logic [1:0] {ext_zero, ext_sign, ext_upper} ext_e;

    typedef enum logic [2:0] {wb_alu, wb_mem, wb_link, wb_imm, wb_shift} wb_src_e;

    typedef enum logic [1:0] {npc_seq, npc_branch, npc_jump} npc_e;

    typedef enum logic [3:0] {
        st_fetch, st_decode, st_alu_exe, st_alu_wb, st_mem_addr, st_mem_store, st_mem_load,
        st_mem_wb, st_beq_exe, st_jal_exe, st_lui_wb, st_shift_exe, st_shift_wb
    } state_e;

    typedef struct packed {
        instr_op_e op;
        alu_op_e   alu_op;
        ext_e      ext;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t dst;
        logic [4:0]  shamt;
        logic        shift_var;
        logic        check_ovf;
        logic [15:0] imm;
        logic [25:0] jidx;
    } decoded_t;

    typedef struct packed {
        logic    rf_we;
        logic    pc_we;
        logic    ir_we;
        logic    dm_we;
        logic    op2_imm;
        wb_src_e wb_src;
        npc_e    npc;
    } ctrl_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t addr;
        word_t     data;
    } rf_write_t;

endpackage

`default_nettype wire

// File: hdl/mips_regfile.sv
`timescale 1ns/1ns
`default_nettype none

module mips_regfile (
    input  logic                clk,
    input  logic                rst,
    input  mips_pkg::reg_addr_t rs_addr,
    input  mips_pkg::reg_addr_t rt_addr,
    output mips_pkg::word_t     rs_data,
    output mips_pkg::word_t     rt_data,
    input  mips_pkg::rf_write_t wr
);
    import mips_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.valid && wr.addr != '0) begin
            regs[wr.addr] <= wr.data;
        end
    end

    // r0 always reads zero
    assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

endmodule

`default_nettype wire

// File: hdl/word_ram.sv
`timescale 1ns/1ns
`default_nettype none

module word_ram #(
    parameter int depth = 256
) (
    input  logic                          clk,
    input  logic                          we,
    input  logic [mips_pkg::mem_addr_w-1:0] waddr,
    input  mips_pkg::word_t               wdata,
    input  logic [mips_pkg::mem_addr_w-1:0] raddr,
    output mips_pkg::word_t               rdata
);
    import mips_pkg::*;

    word_t mem [depth];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    assign rdata = mem[raddr];

endmodule

`default_nettype wire

// File: tb.f
hdl/mips_pkg.sv
hdl/word_ram.sv
hdl/mips_decoder.sv
hdl/mips_control.sv
hdl/mips_regfile.sv
hdl/mips_execute.sv
hdl/mips_core.sv
tests/mips_properties.sv
tests/mips_tb.sv

// File: tests/mips_properties.sv
`timescale 1ns/1ns
`default_nettype none

module mips_properties (
    input logic                clk,
    input logic                rst,
    input mips_pkg::state_e    state,
    input mips_pkg::ctrl_t     ctrl,
    input mips_pkg::rf_write_t rf_trace,
    input logic                integer_overflow
);
    import mips_pkg::*;

    ir_load_in_fetch: assert property (@(posedge clk) disable iff (rst)
        ctrl.ir_we |-> state == st_fetch)
        else $error("instruction register written outside fetch");

    dm_write_in_store: assert property (@(posedge clk) disable iff (rst)
        ctrl.dm_we |-> state == st_mem_store)
        else $error("data memory written outside mem_store");

    // a suppressed write never shows on the trace
    trace_not_on_overflow: assert property (@(posedge clk) disable iff (rst)
        !(rf_trace.valid && integer_overflow))
        else $error("trace pulse together with integer overflow");

    no_zero_reg_trace: assert property (@(posedge clk) disable iff (rst)
        rf_trace.valid |-> rf_trace.addr != '0)
        else $error("trace pulse names register zero");

endmodule

bind mips_core mips_properties mips_properties_i (
    .clk(clk), .rst(rst), .state(state), .ctrl(ctrl), .rf_trace(rf_trace),
    .integer_overflow(integer_overflow)
);

`default_nettype wire

// File: tests/mips_tb.sv
`timescale 1ns/1ns
`default_nettype none

module mips_tb;
    import mips_pkg::*;

    localparam int trace_timeout = 400;
    localparam reg_addr_t end_reg = 5'd30;
    localparam word_t end_mark = 32'h0000_e0d0;

    logic                  clk;
    logic                  rst;
    logic                  run;
    logic                  prog_we;
    logic [mem_addr_w-1:0] prog_addr;
    word_t                 prog_data;
    rf_write_t             rf_trace;
    logic                  integer_overflow;

    word_t       prog [$];
    rf_write_t   want [$];
    rf_write_t   seen [$];

    mips_core mips_core_i (
        .clk(clk), .rst(rst), .run(run), .prog_we(prog_we), .prog_addr(prog_addr),
        .prog_data(prog_data), .rf_trace(rf_trace), .integer_overflow(integer_overflow)
    );

    always #4 clk = ~clk;

    function automatic word_t rtype(funct_e f, reg_addr_t rs, reg_addr_t rt, reg_addr_t rd,
                                    logic [4:0] sh);
        return {op_special, rs, rt, rd, sh, f};
    endfunction

    function automatic word_t itype(opcode_e op, reg_addr_t rs, reg_addr_t rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t jtype(opcode_e op, logic [25:0] idx);
        return {op, idx};
    endfunction

    function automatic word_t sext16(logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    // random value kept within +-2^30 so add and sub never overflow
    function automatic word_t bounded_rand();
        word_t x;
        x = $urandom;
        return {{2{x[29]}}, x[29:0]};
    endfunction

    function automatic rf_write_t reg_write(reg_addr_t a, word_t d);
        rf_write_t w;
        w.valid = 1'b1;
        w.addr = a;
        w.data = d;
        return w;
    endfunction

    task automatic abort_run(string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_write(string name, rf_write_t exp, rf_write_t act);
        if (exp !== act) begin
            abort_run($sformatf("ERR %s: expected r%0d=%h valid=%b, actual r%0d=%h valid=%b",
                                name, exp.addr, exp.data, exp.valid,
                                act.addr, act.data, act.valid));
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (exp !== act) begin
            abort_run($sformatf("ERR %s: expected overflow %b, actual %b", name, exp, act));
        end
    endtask

    task automatic check_count(string name, int exp, int act);
        if (exp != act) begin
            abort_run($sformatf("ERR %s: expected %0d register writes, actual %0d",
                                name, exp, act));
        end
    endtask

    task automatic new_program();
        prog.delete();
        want.delete();
    endtask

    task automatic append_instr(word_t ins);
        prog.push_back(ins);
    endtask

    task automatic expect_result(word_t ins, reg_addr_t dst, word_t value);
        prog.push_back(ins);
        want.push_back(reg_write(dst, value));
    endtask

    task automatic set_reg(reg_addr_t r, word_t v);
        expect_result(itype(op_lui, 5'd0, r, v[31:16]), r, {v[31:16], 16'h0000});
        expect_result(itype(op_ori, r, r, v[15:0]), r, v);
    endtask

    // marker write, then a branch onto itself
    task automatic finish_program();
        append_instr(itype(op_ori, 5'd0, end_reg, end_mark[15:0]));
        append_instr(itype(op_beq, 5'd0, 5'd0, 16'hffff));
    endtask

    task automatic run_program(string name, logic exp_ovf);
        int   cycles;
        logic done;
        logic ovf_hit;
        @(negedge clk);
        run = 1'b0;
        foreach (prog[i]) begin
            prog_we = 1'b1;
            prog_addr = mem_addr_w'(i);
            prog_data = prog[i];
            @(negedge clk);
        end
        prog_we = 1'b0;
        rst = 1'b1;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        run = 1'b1;
        seen.delete();
        cycles = 0;
        done = 1'b0;
        ovf_hit = 1'b0;
        while (!done) begin
            @(negedge clk);
            cycles++;
            if (integer_overflow) begin
                ovf_hit = 1'b1;
            end
            if (rf_trace.valid && rf_trace.addr == end_reg && rf_trace.data == end_mark) begin
                done = 1'b1;
            end else if (rf_trace.valid) begin
                seen.push_back(rf_trace);
            end
            if (!done && cycles >= trace_timeout) begin
                abort_run($sformatf("%s: core never reached the end marker within %0d cycles",
                                    name, trace_timeout));
            end
        end
        run = 1'b0;
        check_count(name, want.size(), seen.size());
        foreach (want[i]) begin
            check_write(name, want[i], seen[i]);
        end
        check_flag(name, exp_ovf, ovf_hit);
    endtask

    task automatic alu_test(int pass);
        word_t       a;
        word_t       b;
        logic [15:0] imm;
        word_t       simm;
        word_t       zimm;
        a = bounded_rand();
        b = bounded_rand();
        imm = 16'($urandom);
        simm = sext16(imm);
        zimm = {16'h0000, imm};
        new_program();
        set_reg(5'd1, a);
        set_reg(5'd2, b);
        expect_result(rtype(f_add, 5'd1, 5'd2, 5'd3, 5'd0), 5'd3, a + b);
        expect_result(rtype(f_addu, 5'd1, 5'd2, 5'd4, 5'd0), 5'd4, a + b);
        expect_result(rtype(f_sub, 5'd1, 5'd2, 5'd5, 5'd0), 5'd5, a - b);
        expect_result(rtype(f_subu, 5'd1, 5'd2, 5'd6, 5'd0), 5'd6, a - b);
        expect_result(rtype(f_and, 5'd1, 5'd2, 5'd7, 5'd0), 5'd7, a & b);
        expect_result(rtype(f_or, 5'd1, 5'd2, 5'd8, 5'd0), 5'd8, a | b);
        expect_result(rtype(f_xor, 5'd1, 5'd2, 5'd9, 5'd0), 5'd9, a ^ b);
        expect_result(rtype(f_nor, 5'd1, 5'd2, 5'd10, 5'd0), 5'd10, ~(a | b));
        expect_result(rtype(f_slt, 5'd1, 5'd2, 5'd11, 5'd0), 5'd11,
                      {31'd0, $signed(a) < $signed(b)});
        expect_result(rtype(f_sltu, 5'd1, 5'd2, 5'd12, 5'd0), 5'd12, {31'd0, a < b});
        // arithmetic and compare immediates are sign-extended
        expect_result(itype(op_addi, 5'd1, 5'd13, imm), 5'd13, a + simm);
        expect_result(itype(op_addiu, 5'd1, 5'd14, imm), 5'd14, a + simm);
        expect_result(itype(op_slti, 5'd1, 5'd15, imm), 5'd15,
                      {31'd0, $signed(a) < $signed(simm)});
        expect_result(itype(op_sltiu, 5'd1, 5'd16, imm), 5'd16, {31'd0, a < simm});
        expect_result(itype(op_andi, 5'd1, 5'd17, imm), 5'd17, a & zimm);
        expect_result(itype(op_ori, 5'd1, 5'd18, imm), 5'd18, a | zimm);
        expect_result(itype(op_xori, 5'd1, 5'd19, imm), 5'd19, a ^ zimm);
        finish_program();
        run_program($sformatf("alu_%0d", pass), 1'b0);
    endtask

    task automatic shift_test();
        word_t       v;
        word_t       s;
        logic [4:0]  sh;
        logic [15:0] imm;
        v = $urandom;
        s = $urandom;
        sh = 5'($urandom);
        imm = 16'($urandom);
        new_program();
        set_reg(5'd1, v);
        set_reg(5'd2, s);
        expect_result(itype(op_lui, 5'd0, 5'd3, imm), 5'd3, {imm, 16'h0000});
        expect_result(rtype(f_sll, 5'd0, 5'd1, 5'd4, sh), 5'd4, v << sh);
        expect_result(rtype(f_sllv, 5'd2, 5'd1, 5'd5, 5'd0), 5'd5, v << s[4:0]);
        finish_program();
        run_program("shift", 1'b0);
    endtask

    task automatic memory_test();
        word_t w0;
        word_t w1;
        word_t base;
        w0 = $urandom;
        w1 = $urandom;
        base = word_t'(($urandom % 240) * 4);
        new_program();
        set_reg(5'd1, w0);
        set_reg(5'd2, base);
        set_reg(5'd3, w1);
        append_instr(itype(op_sw, 5'd2, 5'd1, 16'd8));
        append_instr(itype(op_sw, 5'd2, 5'd3, 16'd12));
        expect_result(itype(op_lw, 5'd2, 5'd4, 16'd8), 5'd4, w0);
        expect_result(itype(op_lw, 5'd2, 5'd5, 16'd12), 5'd5, w1);
        finish_program();
        run_program("memory", 1'b0);
    endtask

    task automatic branch_test();
        word_t v;
        int    k;
        v = $urandom;
        new_program();
        set_reg(5'd1, v);
        set_reg(5'd2, v);
        set_reg(5'd3, v ^ 32'd1);
        // taken branch skips the first ori
        append_instr(itype(op_beq, 5'd1, 5'd2, 16'd1));
        append_instr(itype(op_ori, 5'd0, 5'd4, 16'h0111));
        expect_result(itype(op_ori, 5'd0, 5'd5, 16'h0222), 5'd5, 32'h0000_0222);
        append_instr(itype(op_beq, 5'd1, 5'd3, 16'd1));
        expect_result(itype(op_ori, 5'd0, 5'd6, 16'h0333), 5'd6, 32'h0000_0333);
        expect_result(itype(op_ori, 5'd0, 5'd7, 16'h0444), 5'd7, 32'h0000_0444);
        k = prog.size();
        expect_result(jtype(op_jal, 26'(k + 2)), 5'd31, word_t'(k * 4 + 4));
        append_instr(itype(op_ori, 5'd0, 5'd8, 16'h0555));
        expect_result(itype(op_ori, 5'd0, 5'd9, 16'h0666), 5'd9, 32'h0000_0666);
        finish_program();
        run_program("branch", 1'b0);
    endtask

    task automatic overflow_test();
        word_t a;
        word_t b;
        word_t op_ins;
        word_t wrap_ins;
        word_t wrap;
        for (int c = 0; c < 3; c++) begin
            a = 32'h7fff_0000 | word_t'($urandom % 16'hffff);
            b = 32'h0100_0000;
            op_ins = rtype(f_add, 5'd1, 5'd2, 5'd3, 5'd0);
            wrap_ins = rtype(f_addu, 5'd1, 5'd2, 5'd4, 5'd0);
            wrap = a + b;
            if (c == 1) begin
                op_ins = itype(op_addi, 5'd1, 5'd3, 16'h7fff);
                wrap_ins = itype(op_addiu, 5'd1, 5'd4, 16'h7fff);
                a = 32'h7fff_ff00;
                wrap = a + 32'h0000_7fff;
            end else if (c == 2) begin
                // negative minus positive wraps to positive
                a = 32'h8000_0000 | word_t'($urandom % 16'hffff);
                op_ins = rtype(f_sub, 5'd1, 5'd2, 5'd3, 5'd0);
                wrap_ins = rtype(f_subu, 5'd1, 5'd2, 5'd4, 5'd0);
                wrap = a - b;
            end
            new_program();
            set_reg(5'd1, a);
            set_reg(5'd2, b);
            append_instr(op_ins);
            expect_result(wrap_ins, 5'd4, wrap);
            append_instr(rtype(f_addu, 5'd1, 5'd2, 5'd0, 5'd0));
            finish_program();
            run_program($sformatf("overflow_%0d", c), 1'b1);
        end
    endtask

    initial begin
        void'($urandom(32'hc6688180));
        clk = 1'b0;
        rst = 1'b1;
        run = 1'b0;
        prog_we = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        for (int i = 0; i < 4; i++) begin
            alu_test(i);
        end
        shift_test();
        memory_test();
        branch_test();
        overflow_test();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire
